//--- Makefile
VERILATOR := verilator
TOP       := core_tb
FILELIST  := filelist.f
VFLAGS    := --binary --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/core_top.sv
tb/tb_clock.sv
tb/core_tb.sv

//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file
`define CORE_DATA_WIDTH     32
`define CORE_REG_BITS       5
`define CORE_NUM_REGS       32
`define CORE_IMM_BITS       16

// data memory, word addressed
`define CORE_MEM_ADDR_BITS  8
`define CORE_MEM_WORDS      256

// instruction fields
`define CORE_OPCODE_MSB     31
`define CORE_OPCODE_LSB     26
`define CORE_RS_MSB         25
`define CORE_RS_LSB         21
`define CORE_RT_MSB         20
`define CORE_RT_LSB         16
`define CORE_RD_MSB         15
`define CORE_RD_LSB         11
`define CORE_IMM_MSB        15
`define CORE_IMM_LSB        0

`endif

//--- hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module core_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        instr_valid,
  input  logic [`CORE_DATA_WIDTH-1:0] instr,
  output logic                        wb_valid,
  output logic [`CORE_REG_BITS-1:0]   wb_reg,
  output logic [`CORE_DATA_WIDTH-1:0] wb_data
);

  // register file read port
  logic [`CORE_REG_BITS-1:0]   rs_addr;
  logic [`CORE_REG_BITS-1:0]   rt_addr;
  logic [`CORE_DATA_WIDTH-1:0] rs_data;
  logic [`CORE_DATA_WIDTH-1:0] rt_data;

  // decode/execute register
  logic                        ex_valid;
  logic [`CORE_REG_BITS-1:0]   ex_rs;
  logic [`CORE_REG_BITS-1:0]   ex_rt;
  logic [`CORE_REG_BITS-1:0]   ex_dst;
  logic [`CORE_DATA_WIDTH-1:0] ex_rs_data;
  logic [`CORE_DATA_WIDTH-1:0] ex_rt_data;
  logic [`CORE_IMM_BITS-1:0]   ex_imm;
  pipe_pkg::alu_op_e           ex_alu_op;
  logic                        ex_alu_src;
  pipe_pkg::mem_op_e           ex_mem_op;
  logic                        ex_reg_write;

  // execute/memory register
  logic                          m_valid;
  logic [`CORE_REG_BITS-1:0]     m_dst;
  logic                          m_reg_write;
  pipe_pkg::mem_op_e             m_mem_op;
  logic [`CORE_MEM_ADDR_BITS-1:0] m_addr;
  logic [`CORE_DATA_WIDTH-1:0]   m_result;
  logic [`CORE_DATA_WIDTH-1:0]   m_store_data;

  // memory stage result, offered for forwarding
  logic                        mem_fwd_valid;
  logic [`CORE_REG_BITS-1:0]   mem_fwd_reg;
  logic [`CORE_DATA_WIDTH-1:0] mem_fwd_data;

  decode_stage decode_i (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs_addr      (rs_addr),
    .rt_addr      (rt_addr),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .ex_valid     (ex_valid),
    .ex_rs        (ex_rs),
    .ex_rt        (ex_rt),
    .ex_dst       (ex_dst),
    .ex_rs_data   (ex_rs_data),
    .ex_rt_data   (ex_rt_data),
    .ex_imm       (ex_imm),
    .ex_alu_op    (ex_alu_op),
    .ex_alu_src   (ex_alu_src),
    .ex_mem_op    (ex_mem_op),
    .ex_reg_write (ex_reg_write)
  );

  register_file regfile_i (
    .clk     (clk),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (wb_valid),
    .wr_reg  (wb_reg),
    .wr_data (wb_data)
  );

  execute_stage execute_i (
    .clk           (clk),
    .rst           (rst),
    .ex_valid      (ex_valid),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .ex_dst        (ex_dst),
    .ex_rs_data    (ex_rs_data),
    .ex_rt_data    (ex_rt_data),
    .ex_imm        (ex_imm),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src    (ex_alu_src),
    .ex_mem_op     (ex_mem_op),
    .ex_reg_write  (ex_reg_write),
    .mem_fwd_valid (mem_fwd_valid),
    .mem_fwd_reg   (mem_fwd_reg),
    .mem_fwd_data  (mem_fwd_data),
    .wb_valid      (wb_valid),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data),
    .m_valid       (m_valid),
    .m_dst         (m_dst),
    .m_reg_write   (m_reg_write),
    .m_mem_op      (m_mem_op),
    .m_addr        (m_addr),
    .m_result      (m_result),
    .m_store_data  (m_store_data)
  );

  mem_stage mem_i (
    .clk           (clk),
    .rst           (rst),
    .m_valid       (m_valid),
    .m_dst         (m_dst),
    .m_reg_write   (m_reg_write),
    .m_mem_op      (m_mem_op),
    .m_addr        (m_addr),
    .m_result      (m_result),
    .m_store_data  (m_store_data),
    .mem_fwd_valid (mem_fwd_valid),
    .mem_fwd_reg   (mem_fwd_reg),
    .mem_fwd_data  (mem_fwd_data),
    .wb_valid      (wb_valid),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data)
  );

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module decode_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        instr_valid,
  input  logic [`CORE_DATA_WIDTH-1:0] instr,
  output logic [`CORE_REG_BITS-1:0]   rs_addr,
  output logic [`CORE_REG_BITS-1:0]   rt_addr,
  input  logic [`CORE_DATA_WIDTH-1:0] rs_data,
  input  logic [`CORE_DATA_WIDTH-1:0] rt_data,
  output logic                        ex_valid,
  output logic [`CORE_REG_BITS-1:0]   ex_rs,
  output logic [`CORE_REG_BITS-1:0]   ex_rt,
  output logic [`CORE_REG_BITS-1:0]   ex_dst,
  output logic [`CORE_DATA_WIDTH-1:0] ex_rs_data,
  output logic [`CORE_DATA_WIDTH-1:0] ex_rt_data,
  output logic [`CORE_IMM_BITS-1:0]   ex_imm,
  output pipe_pkg::alu_op_e           ex_alu_op,
  output logic                        ex_alu_src,
  output pipe_pkg::mem_op_e           ex_mem_op,
  output logic                        ex_reg_write
);

  isa_pkg::opcode_e          opcode;
  isa_pkg::instr_class_e     op_cls;
  logic [`CORE_REG_BITS-1:0] rd;
  logic [`CORE_REG_BITS-1:0] dst;
  pipe_pkg::alu_op_e         alu_op;
  pipe_pkg::mem_op_e         mem_op;
  logic                      alu_src;
  logic                      reg_write;

  //////////////////////////////////////////////////////////////////////
  // field extraction

  assign opcode  = isa_pkg::opcode_e'(instr[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB]);
  assign rs_addr = instr[`CORE_RS_MSB:`CORE_RS_LSB];
  assign rt_addr = instr[`CORE_RT_MSB:`CORE_RT_LSB];
  assign rd      = instr[`CORE_RD_MSB:`CORE_RD_LSB];
  assign op_cls  = isa_pkg::op_class(opcode);

  //////////////////////////////////////////////////////////////////////
  // control table

  always_comb begin
    case (opcode)
      isa_pkg::OP_SUB: alu_op = pipe_pkg::ALU_SUB;
      isa_pkg::OP_AND: alu_op = pipe_pkg::ALU_AND;
      isa_pkg::OP_OR,
      isa_pkg::OP_ORI: alu_op = pipe_pkg::ALU_OR;
      isa_pkg::OP_SLT: alu_op = pipe_pkg::ALU_SLT;
      // add also forms load/store addresses
      default: alu_op = pipe_pkg::ALU_ADD;
    endcase

    case (op_cls)
      isa_pkg::CLS_LOAD:  mem_op = pipe_pkg::MEM_LOAD;
      isa_pkg::CLS_STORE: mem_op = pipe_pkg::MEM_STORE;
      default:            mem_op = pipe_pkg::MEM_NONE;
    endcase

    alu_src = (op_cls == isa_pkg::CLS_IMM) || (op_cls == isa_pkg::CLS_LOAD) ||
              (op_cls == isa_pkg::CLS_STORE);
    dst = (op_cls == isa_pkg::CLS_REG) ? rd : rt_addr;
    // r0 is never written
    reg_write = ((op_cls == isa_pkg::CLS_REG) || (op_cls == isa_pkg::CLS_IMM) ||
                 (op_cls == isa_pkg::CLS_LOAD)) && (dst != '0);
  end

  //////////////////////////////////////////////////////////////////////
  // decode/execute register

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_op    <= pipe_pkg::MEM_NONE;
    end else begin
      ex_valid     <= instr_valid;
      ex_reg_write <= instr_valid & reg_write;
      ex_mem_op    <= instr_valid ? mem_op : pipe_pkg::MEM_NONE;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs      <= rs_addr;
    ex_rt      <= rt_addr;
    ex_dst     <= dst;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
    ex_imm     <= instr[`CORE_IMM_MSB:`CORE_IMM_LSB];
    ex_alu_op  <= alu_op;
    ex_alu_src <= alu_src;
  end

  // a store never writes a register
  store_no_write_a: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> !(ex_reg_write && ex_mem_op == pipe_pkg::MEM_STORE));

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module execute_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ex_valid,
  input  logic [`CORE_REG_BITS-1:0]      ex_rs,
  input  logic [`CORE_REG_BITS-1:0]      ex_rt,
  input  logic [`CORE_REG_BITS-1:0]      ex_dst,
  input  logic [`CORE_DATA_WIDTH-1:0]    ex_rs_data,
  input  logic [`CORE_DATA_WIDTH-1:0]    ex_rt_data,
  input  logic [`CORE_IMM_BITS-1:0]      ex_imm,
  input  pipe_pkg::alu_op_e              ex_alu_op,
  input  logic                           ex_alu_src,
  input  pipe_pkg::mem_op_e              ex_mem_op,
  input  logic                           ex_reg_write,
  input  logic                           mem_fwd_valid,
  input  logic [`CORE_REG_BITS-1:0]      mem_fwd_reg,
  input  logic [`CORE_DATA_WIDTH-1:0]    mem_fwd_data,
  input  logic                           wb_valid,
  input  logic [`CORE_REG_BITS-1:0]      wb_reg,
  input  logic [`CORE_DATA_WIDTH-1:0]    wb_data,
  output logic                           m_valid,
  output logic [`CORE_REG_BITS-1:0]      m_dst,
  output logic                           m_reg_write,
  output pipe_pkg::mem_op_e              m_mem_op,
  output logic [`CORE_MEM_ADDR_BITS-1:0] m_addr,
  output logic [`CORE_DATA_WIDTH-1:0]    m_result,
  output logic [`CORE_DATA_WIDTH-1:0]    m_store_data
);

  pipe_pkg::fwd_sel_e          rs_sel;
  pipe_pkg::fwd_sel_e          rt_sel;
  logic [`CORE_DATA_WIDTH-1:0] op_a;
  logic [`CORE_DATA_WIDTH-1:0] rt_fwd;
  logic [`CORE_DATA_WIDTH-1:0] op_b;
  logic [`CORE_DATA_WIDTH-1:0] alu_sum;
  logic [`CORE_DATA_WIDTH-1:0] alu_result;

  //////////////////////////////////////////////////////////////////////
  // forwarding unit

  // younger producer wins, r0 is never forwarded
  function automatic pipe_pkg::fwd_sel_e fwd_select(
    input logic [`CORE_REG_BITS-1:0] src
  );
    if (src == '0) begin
      fwd_select = pipe_pkg::FWD_REG;
    end else if (mem_fwd_valid && mem_fwd_reg == src) begin
      fwd_select = pipe_pkg::FWD_EX_MEM;
    end else if (wb_valid && wb_reg == src) begin
      fwd_select = pipe_pkg::FWD_MEM_WB;
    end else begin
      fwd_select = pipe_pkg::FWD_REG;
    end
  endfunction

  function automatic logic [`CORE_DATA_WIDTH-1:0] fwd_mux(
    input pipe_pkg::fwd_sel_e          sel,
    input logic [`CORE_DATA_WIDTH-1:0] reg_val
  );
    case (sel)
      pipe_pkg::FWD_EX_MEM: fwd_mux = mem_fwd_data;
      pipe_pkg::FWD_MEM_WB: fwd_mux = wb_data;
      default:              fwd_mux = reg_val;
    endcase
  endfunction

  always_comb begin
    rs_sel = fwd_select(ex_rs);
    rt_sel = fwd_select(ex_rt);
    op_a   = fwd_mux(rs_sel, ex_rs_data);
    rt_fwd = fwd_mux(rt_sel, ex_rt_data);
  end

  //////////////////////////////////////////////////////////////////////
  // alu

  // immediate is zero-extended
  assign op_b = ex_alu_src ?
                {{(`CORE_DATA_WIDTH-`CORE_IMM_BITS){1'b0}}, ex_imm} : rt_fwd;
  assign alu_sum = op_a + op_b;

  always_comb begin
    case (ex_alu_op)
      pipe_pkg::ALU_SUB: alu_result = op_a - op_b;
      pipe_pkg::ALU_AND: alu_result = op_a & op_b;
      pipe_pkg::ALU_OR:  alu_result = op_a | op_b;
      pipe_pkg::ALU_SLT: begin
        alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
      end
      default: alu_result = alu_sum;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // execute/memory register

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid     <= 1'b0;
      m_reg_write <= 1'b0;
      m_mem_op    <= pipe_pkg::MEM_NONE;
    end else begin
      m_valid     <= ex_valid;
      m_reg_write <= ex_valid & ex_reg_write;
      m_mem_op    <= ex_valid ? ex_mem_op : pipe_pkg::MEM_NONE;
    end
  end

  always_ff @(posedge clk) begin
    m_dst        <= ex_dst;
    m_addr       <= alu_sum[`CORE_MEM_ADDR_BITS-1:0];
    m_result     <= alu_result;
    m_store_data <= rt_fwd;
  end

  // memory stage must really be writing a non-zero register
  fwd_ex_mem_a: assert property (@(posedge clk) disable iff (rst)
    (rs_sel == pipe_pkg::FWD_EX_MEM || rt_sel == pipe_pkg::FWD_EX_MEM) |->
      (m_valid && m_reg_write && m_dst != '0));

endmodule

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // opcode field, unlisted codes behave as nop
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_SLT  = 6'd5,
    OP_ADDI = 6'd6,
    OP_ORI  = 6'd7,
    OP_LW   = 6'd8,
    OP_SW   = 6'd9
  } opcode_e;

  // how an instruction uses its fields
  typedef enum logic [2:0] {
    CLS_NONE,
    CLS_REG,
    CLS_IMM,
    CLS_LOAD,
    CLS_STORE
  } instr_class_e;

  function automatic instr_class_e op_class(opcode_e op);
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: op_class = CLS_REG;
      OP_ADDI, OP_ORI: op_class = CLS_IMM;
      OP_LW: op_class = CLS_LOAD;
      OP_SW: op_class = CLS_STORE;
      default: op_class = CLS_NONE;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module mem_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           m_valid,
  input  logic [`CORE_REG_BITS-1:0]      m_dst,
  input  logic                           m_reg_write,
  input  pipe_pkg::mem_op_e              m_mem_op,
  input  logic [`CORE_MEM_ADDR_BITS-1:0] m_addr,
  input  logic [`CORE_DATA_WIDTH-1:0]    m_result,
  input  logic [`CORE_DATA_WIDTH-1:0]    m_store_data,
  output logic                           mem_fwd_valid,
  output logic [`CORE_REG_BITS-1:0]      mem_fwd_reg,
  output logic [`CORE_DATA_WIDTH-1:0]    mem_fwd_data,
  output logic                           wb_valid,
  output logic [`CORE_REG_BITS-1:0]      wb_reg,
  output logic [`CORE_DATA_WIDTH-1:0]    wb_data
);

  logic [`CORE_DATA_WIDTH-1:0] mem [`CORE_MEM_WORDS];
  logic [`CORE_DATA_WIDTH-1:0] load_data;
  logic [`CORE_DATA_WIDTH-1:0] sel_data;

  always_ff @(posedge clk) begin
    if (m_valid && m_mem_op == pipe_pkg::MEM_STORE) begin
      mem[m_addr] <= m_store_data;
    end
  end

  // combinational read, so loads forward like alu results
  assign load_data = mem[m_addr];
  assign sel_data  = (m_mem_op == pipe_pkg::MEM_LOAD) ? load_data : m_result;

  assign mem_fwd_valid = m_valid & m_reg_write;
  assign mem_fwd_reg   = m_dst;
  assign mem_fwd_data  = sel_data;

  // memory/writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= m_valid & m_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= m_dst;
    wb_data <= sel_data;
  end

  // a load to a real register keeps its write enable through execute
  load_writes_a: assert property (@(posedge clk) disable iff (rst)
    (m_valid && m_mem_op == pipe_pkg::MEM_LOAD && m_dst != '0) |-> m_reg_write);

endmodule

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_sel_e;

endpackage

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module register_file (
  input  logic                        clk,
  input  logic [`CORE_REG_BITS-1:0]   rs_addr,
  input  logic [`CORE_REG_BITS-1:0]   rt_addr,
  output logic [`CORE_DATA_WIDTH-1:0] rs_data,
  output logic [`CORE_DATA_WIDTH-1:0] rt_data,
  input  logic                        wr_en,
  input  logic [`CORE_REG_BITS-1:0]   wr_reg,
  input  logic [`CORE_DATA_WIDTH-1:0] wr_data
);

  logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_NUM_REGS];

  always_ff @(posedge clk) begin
    if (wr_en && wr_reg != '0) begin
      regs[wr_reg] <= wr_data;
    end
  end

  // write-through, so a reader in the same cycle sees the new value
  function automatic logic [`CORE_DATA_WIDTH-1:0] read_port(
    input logic [`CORE_REG_BITS-1:0] addr
  );
    if (addr == '0) begin
      read_port = '0;
    end else if (wr_en && wr_reg == addr) begin
      read_port = wr_data;
    end else begin
      read_port = regs[addr];
    end
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

endmodule

`default_nettype wire

//--- tb/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module core_tb;

  localparam int ALU_RANDOM = 40;
  localparam int STORES     = 8;
  localparam int LATENCY    = 3;
  // upper bound on cycles per test, reset through no-writeback
  localparam int TEST_CYCLES = 12 + (31 + 6 + 2 * ALU_RANDOM + 4) + (8 * 6 + 8) +
                               (2 * STORES + 16) + 20;

  typedef struct packed {
    logic                        valid;
    logic [`CORE_REG_BITS-1:0]   dst;
    logic [`CORE_DATA_WIDTH-1:0] data;
  } wb_exp_t;

  logic                        clk;
  logic                        rst;
  logic                        instr_valid;
  logic [`CORE_DATA_WIDTH-1:0] instr;
  logic                        wb_valid;
  logic [`CORE_REG_BITS-1:0]   wb_reg;
  logic [`CORE_DATA_WIDTH-1:0] wb_data;

  logic [`CORE_DATA_WIDTH-1:0] model_regs [`CORE_NUM_REGS];
  logic [`CORE_DATA_WIDTH-1:0] model_mem [`CORE_MEM_WORDS];
  wb_exp_t                     exp_q [$];
  int                          pass_count;
  int                          fail_count;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) clock_i (
    .clk (clk),
    .rst (rst)
  );

  core_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("[ERROR] t=%0t ns %s: got %b, expected %b", $time, name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_reg(input logic [`CORE_REG_BITS-1:0] got,
                           input logic [`CORE_REG_BITS-1:0] exp, input string name);
    if (got !== exp) begin
      $display("[ERROR] t=%0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_data(input logic [`CORE_DATA_WIDTH-1:0] got,
                            input logic [`CORE_DATA_WIDTH-1:0] exp, input string name);
    if (got !== exp) begin
      $display("[ERROR] t=%0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction encoding and reference model

  function automatic logic [`CORE_DATA_WIDTH-1:0] encode_r(
    input logic [`CORE_OPCODE_MSB-`CORE_OPCODE_LSB:0] op,
    input logic [`CORE_REG_BITS-1:0] rd,
    input logic [`CORE_REG_BITS-1:0] rs,
    input logic [`CORE_REG_BITS-1:0] rt
  );
    logic [`CORE_DATA_WIDTH-1:0] word;
    word = '0;
    word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB] = op;
    word[`CORE_RS_MSB:`CORE_RS_LSB] = rs;
    word[`CORE_RT_MSB:`CORE_RT_LSB] = rt;
    word[`CORE_RD_MSB:`CORE_RD_LSB] = rd;
    return word;
  endfunction

  function automatic logic [`CORE_DATA_WIDTH-1:0] encode_i(
    input logic [`CORE_OPCODE_MSB-`CORE_OPCODE_LSB:0] op,
    input logic [`CORE_REG_BITS-1:0] rt,
    input logic [`CORE_REG_BITS-1:0] rs,
    input logic [`CORE_IMM_BITS-1:0] imm
  );
    logic [`CORE_DATA_WIDTH-1:0] word;
    word = '0;
    word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB] = op;
    word[`CORE_RS_MSB:`CORE_RS_LSB] = rs;
    word[`CORE_RT_MSB:`CORE_RT_LSB] = rt;
    word[`CORE_IMM_MSB:`CORE_IMM_LSB] = imm;
    return word;
  endfunction

  // applies one instruction in issue order
  task automatic apply_model(input logic [`CORE_DATA_WIDTH-1:0] word, output wb_exp_t exp);
    logic [`CORE_OPCODE_MSB-`CORE_OPCODE_LSB:0] op;
    logic [`CORE_REG_BITS-1:0]      rs;
    logic [`CORE_REG_BITS-1:0]      rt;
    logic [`CORE_REG_BITS-1:0]      dst;
    logic [`CORE_DATA_WIDTH-1:0]    a;
    logic [`CORE_DATA_WIDTH-1:0]    b;
    logic [`CORE_DATA_WIDTH-1:0]    immx;
    logic [`CORE_DATA_WIDTH-1:0]    res;
    logic [`CORE_MEM_ADDR_BITS-1:0] addr;
    logic                           wr;
    op   = word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB];
    rs   = word[`CORE_RS_MSB:`CORE_RS_LSB];
    rt   = word[`CORE_RT_MSB:`CORE_RT_LSB];
    a    = model_regs[rs];
    b    = model_regs[rt];
    immx = {{(`CORE_DATA_WIDTH-`CORE_IMM_BITS){1'b0}}, word[`CORE_IMM_MSB:`CORE_IMM_LSB]};
    addr = 8'(a + immx);
    dst  = rt;
    res  = '0;
    wr   = 1'b1;
    case (op)
      isa_pkg::OP_ADD:  res = a + b;
      isa_pkg::OP_SUB:  res = a - b;
      isa_pkg::OP_AND:  res = a & b;
      isa_pkg::OP_OR:   res = a | b;
      isa_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::OP_ADDI: res = a + immx;
      isa_pkg::OP_ORI:  res = a | immx;
      isa_pkg::OP_LW:   res = model_mem[addr];
      isa_pkg::OP_SW: begin
        model_mem[addr] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
                   isa_pkg::OP_SLT}) begin
      dst = word[`CORE_RD_MSB:`CORE_RD_LSB];
    end
    exp = '0;
    if (wr && dst != '0) begin
      model_regs[dst] = res;
      exp = '{valid: 1'b1, dst: dst, data: res};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one cycle of stimulus and the writeback check that is due

  task automatic issue(input logic valid, input logic [`CORE_DATA_WIDTH-1:0] word);
    wb_exp_t due;
    wb_exp_t exp;
    @(negedge clk);
    // entry pushed LATENCY negedges ago
    if (exp_q.size() == LATENCY) begin
      due = exp_q.pop_front();
      check_bit(wb_valid, due.valid, "wb_valid");
      if (due.valid) begin
        check_reg(wb_reg, due.dst, "wb_reg");
        check_data(wb_data, due.data, "wb_data");
      end
    end
    exp = '0;
    if (valid && !rst) begin
      apply_model(word, exp);
    end
    exp_q.push_back(exp);
    instr_valid = valid;
    instr       = word;
  endtask

  task automatic drain_pipe();
    repeat (LATENCY + 1) issue(1'b0, $urandom());
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    $display("%s: done, %0d errors", name, fail_count - errors_at_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic reset_test();
    int   errors_at_start;
    logic in_reset;
    errors_at_start = fail_count;
    in_reset = 1'b1;
    // instructions under reset must vanish
    while (in_reset) begin
      issue(1'b1, encode_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234));
      check_bit(wb_valid, 1'b0, "wb_valid");
      in_reset = rst;
    end
    drain_pipe();
    report_test("reset_test", errors_at_start);
  endtask

  task automatic alu_test();
    int                        errors_at_start;
    logic [5:0]                op;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [`CORE_REG_BITS-1:0] rs;
    logic [`CORE_REG_BITS-1:0] rt;
    errors_at_start = fail_count;
    for (int r = 1; r < `CORE_NUM_REGS; r++) begin
      issue(1'b1, encode_i(isa_pkg::OP_ORI, 5'(r), 5'd0, 16'($urandom())));
    end
    // negative operands for the signed compare
    issue(1'b1, encode_r(isa_pkg::OP_SUB, 5'd10, 5'd0, 5'd11));
    issue(1'b1, encode_r(isa_pkg::OP_SUB, 5'd12, 5'd0, 5'd13));
    issue(1'b1, encode_r(isa_pkg::OP_SLT, 5'd14, 5'd10, 5'd11));
    issue(1'b1, encode_r(isa_pkg::OP_SLT, 5'd15, 5'd11, 5'd10));
    issue(1'b1, encode_r(isa_pkg::OP_SLT, 5'd16, 5'd10, 5'd12));
    issue(1'b1, encode_i(isa_pkg::OP_ADDI, 5'd17, 5'd10, 16'hffff));
    for (int i = 0; i < ALU_RANDOM; i++) begin
      if ($urandom_range(3, 0) == 0) begin
        issue(1'b0, $urandom());
      end
      case ($urandom_range(4, 0))
        0: op = isa_pkg::OP_ADD;
        1: op = isa_pkg::OP_SUB;
        2: op = isa_pkg::OP_AND;
        3: op = isa_pkg::OP_OR;
        default: op = isa_pkg::OP_SLT;
      endcase
      rd = 5'($urandom_range(31, 1));
      rs = 5'($urandom_range(31, 0));
      rt = 5'($urandom_range(31, 0));
      issue(1'b1, encode_r(op, rd, rs, rt));
    end
    drain_pipe();
    report_test("alu_test", errors_at_start);
  endtask

  task automatic forwarding_test();
    int errors_at_start;
    errors_at_start = fail_count;
    for (int d = 1; d <= 4; d++) begin
      for (int gap = 0; gap < 2; gap++) begin
        issue(1'b1, encode_i(isa_pkg::OP_ADDI, 5'd20, 5'd0, 16'($urandom())));
        repeat (d - 1) begin
          if (gap != 0) begin
            issue(1'b0, $urandom());
          end else begin
            issue(1'b1, encode_i(isa_pkg::OP_ORI, 5'd21, 5'd0, 16'($urandom())));
          end
        end
        issue(1'b1, encode_r(isa_pkg::OP_ADD, 5'd22, 5'd20, 5'd20));
        issue(1'b1, encode_r(isa_pkg::OP_SUB, 5'd23, 5'd1, 5'd20));
      end
    end
    // two producers in flight, the younger one must win
    issue(1'b1, encode_i(isa_pkg::OP_ADDI, 5'd20, 5'd0, 16'h1111));
    issue(1'b1, encode_i(isa_pkg::OP_ADDI, 5'd20, 5'd0, 16'h2222));
    issue(1'b1, encode_r(isa_pkg::OP_ADD, 5'd22, 5'd20, 5'd0));
    drain_pipe();
    report_test("forwarding_test", errors_at_start);
  endtask

  task automatic memory_test();
    int                             errors_at_start;
    logic [`CORE_MEM_ADDR_BITS-1:0] base;
    logic [`CORE_MEM_ADDR_BITS-1:0] addrs [STORES];
    logic [`CORE_MEM_ADDR_BITS-1:0] extra;
    logic [`CORE_MEM_ADDR_BITS-1:0] offset;
    errors_at_start = fail_count;
    base = 8'($urandom());
    // stride 29 keeps every address distinct
    for (int i = 0; i < STORES; i++) begin
      addrs[i] = base + 8'(i * 29);
      issue(1'b1, encode_i(isa_pkg::OP_SW, 5'($urandom_range(31, 1)), 5'd0,
                           {8'h00, addrs[i]}));
    end
    for (int i = STORES - 1; i >= 0; i--) begin
      issue(1'b1, encode_i(isa_pkg::OP_LW, 5'(i + 2), 5'd0, {8'h00, addrs[i]}));
    end
    // load result used right away
    issue(1'b1, encode_i(isa_pkg::OP_LW, 5'd24, 5'd0, {8'h00, addrs[0]}));
    issue(1'b1, encode_r(isa_pkg::OP_ADD, 5'd25, 5'd24, 5'd24));
    issue(1'b1, encode_r(isa_pkg::OP_SUB, 5'd26, 5'd1, 5'd24));
    // non-zero base register
    offset = addrs[3] - 8'h40;
    issue(1'b1, encode_i(isa_pkg::OP_ORI, 5'd2, 5'd0, 16'h0040));
    issue(1'b1, encode_i(isa_pkg::OP_LW, 5'd27, 5'd2, {8'h00, offset}));
    // store data forwarded, then read straight back
    extra = base + 8'(STORES * 29);
    issue(1'b1, encode_i(isa_pkg::OP_ORI, 5'd3, 5'd0, 16'($urandom())));
    issue(1'b1, encode_i(isa_pkg::OP_SW, 5'd3, 5'd0, {8'h00, extra}));
    issue(1'b1, encode_i(isa_pkg::OP_LW, 5'd28, 5'd0, {8'h00, extra}));
    drain_pipe();
    report_test("memory_test", errors_at_start);
  endtask

  task automatic no_writeback_test();
    int                          errors_at_start;
    logic [`CORE_DATA_WIDTH-1:0] word;
    errors_at_start = fail_count;
    issue(1'b1, encode_i(isa_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0005));
    issue(1'b1, encode_r(isa_pkg::OP_ADD, 5'd0, 5'd1, 5'd2));
    issue(1'b1, encode_r(isa_pkg::OP_ADD, 5'd5, 5'd0, 5'd1));
    issue(1'b1, encode_i(isa_pkg::OP_ORI, 5'd0, 5'd0, 16'hffff));
    issue(1'b1, encode_r(isa_pkg::OP_OR, 5'd6, 5'd0, 5'd0));
    issue(1'b1, 32'h0000_0000);
    issue(1'b1, encode_i(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0011));
    issue(1'b1, encode_i(isa_pkg::OP_LW, 5'd0, 5'd0, 16'h0011));
    // undefined opcodes with random fields
    for (int i = 0; i < 6; i++) begin
      word = $urandom();
      word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB] = 6'($urandom_range(63, 10));
      issue(1'b1, word);
    end
    issue(1'b1, encode_r(isa_pkg::OP_ADD, 5'd7, 5'd0, 5'd0));
    drain_pipe();
    report_test("no_writeback_test", errors_at_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    void'($urandom(78684));
    instr_valid = 1'b0;
    instr       = '0;
    pass_count  = 0;
    fail_count  = 0;
    for (int r = 0; r < `CORE_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    reset_test();
    alu_test();
    forwarding_test();
    memory_test();
    no_writeback_test();
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + 50) * 8);
    $display("watchdog: the tests did not finish within %0d cycles", TEST_CYCLES + 50);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // released right after the last reset edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire
